/* source/img_defines.svh */
`ifndef IMG_DEFINES_SVH
`define IMG_DEFINES_SVH

// Frame geometry
`define IMG_WIDTH 16
`define IMG_HEIGHT 16
`define IMG_PIXELS (`IMG_WIDTH * `IMG_HEIGHT)

// Readout framing, in 16-bit words
`define HEADER_WORDS 4
`define PAD_WORDS 4

// Statistics sample period in x and y
`define STAT_GRID 4

// Thumbnail keeps a 2x2 corner of every 8x8 group
`define THUMB_GRID 8

`endif

/* source/img_pkg.sv */
`include "img_defines.svh"

package img_pkg;

    // Raw sensor sample
    typedef logic [11:0] pixel_t;

    // Memory and stream word
    typedef logic [15:0] word_t;

    // Pixel address inside one block
    typedef logic [$clog2(`IMG_PIXELS)-1:0] addr_t;

    typedef logic block_t;

    // Needs one extra bit to hold a full frame
    typedef logic [$clog2(`IMG_PIXELS):0] count_t;
    typedef logic [$clog2(`IMG_PIXELS):0] stat_t;

    typedef logic [1:0] skip_t;

    typedef enum logic [1:0] {
        cap_idle,
        cap_wait_frame,
        cap_skip_check,
        cap_capture
    } cap_state_t;

endpackage

/* source/stream_pkg.sv */
`include "img_defines.svh"

package stream_pkg;

    typedef logic [`HEADER_WORDS*$bits(img_pkg::word_t)-1:0] header_t;
    typedef logic [2*$bits(img_pkg::word_t)-1:0] checksum_t;

    typedef enum logic {op_capture, op_readout} cmd_op_t;

    typedef struct packed {
        cmd_op_t         op;
        img_pkg::block_t block;
        img_pkg::skip_t  skip;
        logic            thumb;
        header_t         header;
    } cmd_t;

    typedef struct packed {
        img_pkg::count_t pixel_count;
        img_pkg::stat_t  highlight_count;
        img_pkg::stat_t  shadow_count;
    } status_t;

    typedef enum logic [2:0] {ro_idle, ro_header, ro_pixels, ro_checksum, ro_pad} ro_state_t;

endpackage

/* source/fletcher_checksum.sv */
`timescale 1ns/1ns

module fletcher_checksum (
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic                  clear,
    input  logic                  en,
    input  img_pkg::word_t        din,
    output stream_pkg::checksum_t sum
);
    localparam logic [16:0] MODULUS = 17'd65535;

    img_pkg::word_t sum1;
    img_pkg::word_t sum2;
    logic [16:0] s1_add;
    logic [16:0] s2_add;
    img_pkg::word_t s1_next;
    img_pkg::word_t s2_next;

    // One conditional subtract is enough since both operands stay below 2^16
    always_comb begin
        s1_add = {1'b0, sum1} + {1'b0, din};
        s1_next = (s1_add >= MODULUS) ? 16'(s1_add - MODULUS) : s1_add[15:0];
        s2_add = {1'b0, sum2} + {1'b0, s1_next};
        s2_next = (s2_add >= MODULUS) ? 16'(s2_add - MODULUS) : s2_add[15:0];
    end

    always_ff @(posedge clk) begin
        if (!rst_n || clear) begin
            sum1 <= '0;
            sum2 <= '0;
        end else if (en) begin
            sum1 <= s1_next;
            sum2 <= s2_next;
        end
    end

    assign sum = {sum2, sum1};

endmodule

/* source/frame_buffer.sv */
`timescale 1ns/1ns
`include "img_defines.svh"

module frame_buffer (
    input  logic            clk,
    input  logic            wr_en,
    input  img_pkg::block_t wr_block,
    input  img_pkg::addr_t  wr_addr,
    input  img_pkg::word_t  wr_data,
    input  logic            rd_en,
    input  img_pkg::block_t rd_block,
    input  img_pkg::addr_t  rd_addr,
    output img_pkg::word_t  rd_data
);
    // Two blocks of one frame each, block select is the top address bit
    localparam int unsigned DEPTH = 2 * `IMG_PIXELS;

    img_pkg::word_t mem [DEPTH];

    always_ff @(posedge clk) begin
        if (wr_en) begin
            mem[{wr_block, wr_addr}] <= wr_data;
        end
    end

    // Read data holds until the next read
    always_ff @(posedge clk) begin
        if (rd_en) begin
            rd_data <= mem[{rd_block, rd_addr}];
        end
    end

endmodule

/* source/pixel_capture.sv */
`timescale 1ns/1ns
`include "img_defines.svh"

module pixel_capture (
    input  logic                clk,
    input  logic                rst_n,
    input  logic                start,
    input  img_pkg::block_t     block,
    input  img_pkg::skip_t      skip,
    output logic                busy,
    input  logic                img_fv,
    input  logic                img_lv,
    input  img_pkg::pixel_t     img_d,
    output logic                wr_en,
    output img_pkg::block_t     wr_block,
    output img_pkg::addr_t      wr_addr,
    output img_pkg::word_t      wr_data,
    output logic                capture_done,
    output stream_pkg::status_t status
);
    // Top bits looked at for highlight/shadow
    localparam int unsigned STAT_BITS = 7;

    img_pkg::cap_state_t state;
    img_pkg::skip_t skip_q;
    img_pkg::block_t block_q;
    stream_pkg::status_t stats;

    logic fv_prev;
    logic lv_prev;
    logic [$clog2(`IMG_WIDTH)-1:0] col;
    logic [$clog2(`IMG_HEIGHT)-1:0] row;
    logic pixel;
    logic full;
    logic sample;

    assign pixel = img_fv && img_lv;
    assign full = (stats.pixel_count == img_pkg::count_t'(`IMG_PIXELS));
    assign sample = ((col % `STAT_GRID) == 0) && ((row % `STAT_GRID) == 0);

    assign busy = (state != img_pkg::cap_idle);
    assign wr_block = block_q;
    assign status = stats;

    // ======================================================================
    // Frame sequencing and statistics
    // ======================================================================
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state <= img_pkg::cap_idle;
            skip_q <= '0;
            stats <= '0;
            fv_prev <= 1'b0;
            lv_prev <= 1'b0;
            col <= '0;
            row <= '0;
            wr_en <= 1'b0;
            capture_done <= 1'b0;
        end else begin
            wr_en <= 1'b0;
            capture_done <= 1'b0;
            fv_prev <= img_fv;
            lv_prev <= img_lv;

            // Column restarts whenever the line goes low
            col <= img_lv ? col + 1'b1 : '0;
            if (!img_fv) begin
                row <= '0;
            end else if (lv_prev && !img_lv) begin
                row <= row + 1'b1;
            end

            case (state)
                img_pkg::cap_idle: begin
                    if (start) begin
                        stats <= '0;
                        skip_q <= skip;
                        state <= img_pkg::cap_wait_frame;
                    end
                end
                img_pkg::cap_wait_frame: begin
                    if (img_fv && !fv_prev) begin
                        state <= img_pkg::cap_skip_check;
                    end
                end
                img_pkg::cap_skip_check: begin
                    if (skip_q != '0) begin
                        skip_q <= skip_q - 1'b1;
                        state <= img_pkg::cap_wait_frame;
                    end else begin
                        state <= img_pkg::cap_capture;
                    end
                end
                img_pkg::cap_capture: begin
                    if (pixel && !full) begin
                        wr_en <= 1'b1;
                        stats.pixel_count <= stats.pixel_count + 1'b1;
                        if (sample && (img_d[$bits(img_d)-1 -: STAT_BITS] == '1)) begin
                            stats.highlight_count <= stats.highlight_count + 1'b1;
                        end
                        if (sample && (img_d[$bits(img_d)-1 -: STAT_BITS] == '0)) begin
                            stats.shadow_count <= stats.shadow_count + 1'b1;
                        end
                    end
                    if (!img_fv) begin
                        capture_done <= 1'b1;
                        state <= img_pkg::cap_idle;
                    end
                end
                default: state <= img_pkg::cap_idle;
            endcase
        end
    end

    // Write payload, stored little endian
    always_ff @(posedge clk) begin
        if (state == img_pkg::cap_idle && start) begin
            block_q <= block;
        end
        wr_addr <= img_pkg::addr_t'(stats.pixel_count);
        wr_data <= {img_d[7:0], 4'b0000, img_d[11:8]};
    end

endmodule

/* source/readout_engine.sv */
`timescale 1ns/1ns
`include "img_defines.svh"

module readout_engine (
    input  logic                clk,
    input  logic                rst_n,
    input  logic                start,
    input  img_pkg::block_t     block,
    input  logic                thumb,
    input  stream_pkg::header_t header,
    output logic                busy,
    output logic                rd_en,
    output img_pkg::block_t     rd_block,
    output img_pkg::addr_t      rd_addr,
    input  img_pkg::word_t      rd_data,
    output logic                out_valid,
    input  logic                out_ready,
    output img_pkg::word_t      out_data,
    output logic                out_last
);
    localparam int unsigned THUMB_KEEP = 2;
    localparam int unsigned CS_WORDS = $bits(stream_pkg::checksum_t) / $bits(img_pkg::word_t);
    localparam int unsigned CNT_W = $clog2(`HEADER_WORDS + `PAD_WORDS);
    localparam int unsigned SHIFT_W = $bits(stream_pkg::header_t);

    typedef logic [CNT_W-1:0] wcnt_t;

    stream_pkg::ro_state_t state;
    stream_pkg::header_t shift_q;
    wcnt_t word_cnt;
    img_pkg::count_t rd_cnt;
    img_pkg::block_t block_q;
    logic thumb_q;
    logic rd_pend;
    logic rd_keep;

    logic load;
    logic pend_take;
    logic keep_addr;
    logic rd_done;
    logic word_ld;
    logic last_d;
    logic cs_en;
    img_pkg::word_t word_d;
    img_pkg::word_t cs_din;
    stream_pkg::checksum_t cs_sum;
    stream_pkg::checksum_t cs_rev;
    int unsigned rd_col;
    int unsigned rd_row;

    fletcher_checksum u_checksum (
        .clk   (clk),
        .rst_n (rst_n),
        .clear (start),
        .en    (cs_en),
        .din   (cs_din),
        .sum   (cs_sum)
    );

    // ======================================================================
    // Output register and read prefetch
    // ======================================================================
    // Output register can take a word when empty or draining this cycle
    assign load = !out_valid || out_ready;

    assign rd_addr = img_pkg::addr_t'(rd_cnt);
    assign rd_block = block_q;
    assign rd_col = rd_addr % `IMG_WIDTH;
    assign rd_row = rd_addr / `IMG_WIDTH;
    assign keep_addr = !thumb_q || (((rd_col % `THUMB_GRID) < THUMB_KEEP) &&
                                    ((rd_row % `THUMB_GRID) < THUMB_KEEP));
    assign rd_done = (rd_cnt == img_pkg::count_t'(`IMG_PIXELS));

    // Dropped pixels leave without waiting for the output register
    assign pend_take = rd_pend && (load || !rd_keep);
    assign rd_en = (state == stream_pkg::ro_pixels) && !rd_done && (!rd_pend || pend_take);

    always_comb begin
        word_ld = 1'b0;
        last_d = 1'b0;
        word_d = shift_q[SHIFT_W-1 -: $bits(img_pkg::word_t)];
        case (state)
            stream_pkg::ro_header:   word_ld = load;
            stream_pkg::ro_checksum: word_ld = load;
            stream_pkg::ro_pixels: begin
                word_ld = pend_take && rd_keep;
                word_d = rd_data;
            end
            stream_pkg::ro_pad: begin
                word_ld = load;
                word_d = '0;
                last_d = (word_cnt == '0);
            end
            default: word_ld = 1'b0;
        endcase
    end

    // Checksum sees each word byte swapped, then goes out byte reversed
    assign cs_en = word_ld && (state == stream_pkg::ro_header || state == stream_pkg::ro_pixels);
    assign cs_din = {word_d[7:0], word_d[15:8]};
    assign cs_rev = {cs_sum[7:0], cs_sum[15:8], cs_sum[23:16], cs_sum[31:24]};

    assign busy = (state != stream_pkg::ro_idle) || out_valid;

    // ======================================================================
    // Sequencer
    // ======================================================================
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state <= stream_pkg::ro_idle;
            shift_q <= '0;
            word_cnt <= '0;
            rd_cnt <= '0;
            block_q <= '0;
            thumb_q <= 1'b0;
            rd_pend <= 1'b0;
            rd_keep <= 1'b0;
            out_valid <= 1'b0;
            out_last <= 1'b0;
        end else begin
            if (load) begin
                out_valid <= word_ld;
                out_last <= word_ld && last_d;
            end
            rd_pend <= rd_en || (rd_pend && !pend_take);
            if (rd_en) begin
                rd_cnt <= rd_cnt + 1'b1;
                rd_keep <= keep_addr;
            end

            case (state)
                stream_pkg::ro_idle: begin
                    if (start) begin
                        shift_q <= header;
                        word_cnt <= wcnt_t'(`HEADER_WORDS - 1);
                        rd_cnt <= '0;
                        block_q <= block;
                        thumb_q <= thumb;
                        state <= stream_pkg::ro_header;
                    end
                end
                stream_pkg::ro_header, stream_pkg::ro_checksum: begin
                    if (load) begin
                        shift_q <= shift_q << $bits(img_pkg::word_t);
                        word_cnt <= word_cnt - 1'b1;
                        if (word_cnt == '0 && state == stream_pkg::ro_header) begin
                            state <= stream_pkg::ro_pixels;
                        end
                        if (word_cnt == '0 && state == stream_pkg::ro_checksum) begin
                            word_cnt <= wcnt_t'(`PAD_WORDS - 1);
                            state <= stream_pkg::ro_pad;
                        end
                    end
                end
                stream_pkg::ro_pixels: begin
                    // Last pixel already went into the sum a cycle earlier
                    if (rd_done && !rd_pend) begin
                        shift_q <= {cs_rev, {(SHIFT_W - $bits(cs_rev)){1'b0}}};
                        word_cnt <= wcnt_t'(CS_WORDS - 1);
                        state <= stream_pkg::ro_checksum;
                    end
                end
                stream_pkg::ro_pad: begin
                    if (load) begin
                        word_cnt <= word_cnt - 1'b1;
                        if (word_cnt == '0) begin
                            state <= stream_pkg::ro_idle;
                        end
                    end
                end
                default: state <= stream_pkg::ro_idle;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (load && word_ld) begin
            out_data <= word_d;
        end
    end

endmodule

/* source/img_controller.sv */
`timescale 1ns/1ns

module img_controller (
    input  logic                clk,
    input  logic                rst_n,
    input  logic                cmd_valid,
    output logic                cmd_ready,
    input  stream_pkg::cmd_t    cmd,
    input  logic                img_fv,
    input  logic                img_lv,
    input  img_pkg::pixel_t     img_d,
    output logic                out_valid,
    input  logic                out_ready,
    output img_pkg::word_t      out_data,
    output logic                out_last,
    output logic                capture_done,
    output stream_pkg::status_t status
);
    logic cap_busy;
    logic ro_busy;
    logic cap_start;
    logic ro_start;
    logic wr_en;
    img_pkg::block_t wr_block;
    img_pkg::addr_t wr_addr;
    img_pkg::word_t wr_data;
    logic rd_en;
    img_pkg::block_t rd_block;
    img_pkg::addr_t rd_addr;
    img_pkg::word_t rd_data;

    // ======================================================================
    // Command acceptance, one command in flight
    // ======================================================================
    assign cmd_ready = !cap_busy && !ro_busy;
    assign cap_start = cmd_valid && cmd_ready && (cmd.op == stream_pkg::op_capture);
    assign ro_start = cmd_valid && cmd_ready && (cmd.op == stream_pkg::op_readout);

    pixel_capture u_capture (
        .clk          (clk),
        .rst_n        (rst_n),
        .start        (cap_start),
        .block        (cmd.block),
        .skip         (cmd.skip),
        .busy         (cap_busy),
        .img_fv       (img_fv),
        .img_lv       (img_lv),
        .img_d        (img_d),
        .wr_en        (wr_en),
        .wr_block     (wr_block),
        .wr_addr      (wr_addr),
        .wr_data      (wr_data),
        .capture_done (capture_done),
        .status       (status)
    );

    frame_buffer u_buffer (
        .clk      (clk),
        .wr_en    (wr_en),
        .wr_block (wr_block),
        .wr_addr  (wr_addr),
        .wr_data  (wr_data),
        .rd_en    (rd_en),
        .rd_block (rd_block),
        .rd_addr  (rd_addr),
        .rd_data  (rd_data)
    );

    readout_engine u_readout (
        .clk       (clk),
        .rst_n     (rst_n),
        .start     (ro_start),
        .block     (cmd.block),
        .thumb     (cmd.thumb),
        .header    (cmd.header),
        .busy      (ro_busy),
        .rd_en     (rd_en),
        .rd_block  (rd_block),
        .rd_addr   (rd_addr),
        .rd_data   (rd_data),
        .out_valid (out_valid),
        .out_ready (out_ready),
        .out_data  (out_data),
        .out_last  (out_last)
    );

endmodule

/* bench/img_controller_checker.sv */
`timescale 1ns/1ns

module img_controller_checker (
    input logic             clk,
    input logic             rst_n,
    input logic             cmd_valid,
    input logic             cmd_ready,
    input stream_pkg::cmd_t cmd,
    input logic             out_valid,
    input logic             out_ready,
    input img_pkg::word_t   out_data,
    input logic             out_last,
    input logic             capture_done
);
    int unsigned fail_stall;
    int unsigned fail_reset;
    int unsigned fail_pulse;
    int unsigned fail_cmd;
    int unsigned failed_count;
    logic ro_active;

    assign failed_count = fail_stall + fail_reset + fail_pulse + fail_cmd;

    // Readout runs from its handshake until the last word transfers
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            ro_active <= 1'b0;
        end else if (out_valid && out_ready && out_last) begin
            ro_active <= 1'b0;
        end else if (cmd_valid && cmd_ready && (cmd.op == stream_pkg::op_readout)) begin
            ro_active <= 1'b1;
        end
    end

    // ======================================================================
    // Readout stream handshake
    // ======================================================================
    stall_hold_a: assert property (@(posedge clk) disable iff (!rst_n)
        out_valid && !out_ready |=> $stable(out_data) && $stable(out_last))
    else begin
        $error("out_data or out_last changed while the stream was stalled");
        fail_stall++;
    end

    // Output register cleared by reset
    reset_idle_a: assert property (@(posedge clk) !rst_n |=> !out_valid)
    else begin
        $error("out_valid high after a reset cycle");
        fail_reset++;
    end

    // ======================================================================
    // Status and command port
    // ======================================================================
    done_pulse_a: assert property (@(posedge clk) disable iff (!rst_n)
        capture_done |=> !capture_done)
    else begin
        $error("capture_done lasted more than one cycle");
        fail_pulse++;
    end

    busy_cmd_a: assert property (@(posedge clk) disable iff (!rst_n)
        (ro_active || out_valid) |-> !cmd_ready)
    else begin
        $error("cmd_ready high while a readout is still in progress");
        fail_cmd++;
    end

endmodule

bind img_controller img_controller_checker u_checker (
    .clk          (clk),
    .rst_n        (rst_n),
    .cmd_valid    (cmd_valid),
    .cmd_ready    (cmd_ready),
    .cmd          (cmd),
    .out_valid    (out_valid),
    .out_ready    (out_ready),
    .out_data     (out_data),
    .out_last     (out_last),
    .capture_done (capture_done)
);

/* bench/img_controller_tb.sv */
`timescale 1ns/1ns
`include "img_defines.svh"

module img_controller_tb;

    localparam int unsigned TIMEOUT_CYCLES = 2000;
    localparam int unsigned FRAME_STEP = 97;
    localparam int unsigned PIXEL_RANGE = 4096;
    localparam int unsigned FLETCHER_MOD = 65535;
    localparam int unsigned THUMB_KEEP = 2;
    localparam logic [31:0] SEED = 32'hc6457a73;

    logic clk;
    logic rst_n;
    logic cmd_valid;
    logic cmd_ready;
    stream_pkg::cmd_t cmd;
    logic img_fv;
    logic img_lv;
    img_pkg::pixel_t img_d;
    logic out_valid;
    logic out_ready;
    img_pkg::word_t out_data;
    logic out_last;
    logic capture_done;
    stream_pkg::status_t status;

    // Expected contents of both buffer blocks
    img_pkg::word_t model_mem [2][`IMG_PIXELS];
    logic model_full [2];
    img_pkg::word_t expect_q [$];
    int unsigned cases_run;

    img_controller dut_i (
        .clk          (clk),
        .rst_n        (rst_n),
        .cmd_valid    (cmd_valid),
        .cmd_ready    (cmd_ready),
        .cmd          (cmd),
        .img_fv       (img_fv),
        .img_lv       (img_lv),
        .img_d        (img_d),
        .out_valid    (out_valid),
        .out_ready    (out_ready),
        .out_data     (out_data),
        .out_last     (out_last),
        .capture_done (capture_done),
        .status       (status)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    // ======================================================================
    // Reference model
    // ======================================================================
    function automatic img_pkg::pixel_t pattern_pixel(input int unsigned frame,
            input int unsigned base, input int unsigned col_step,
            input int unsigned row_step, input int unsigned col, input int unsigned row);
        return img_pkg::pixel_t'((base + frame * FRAME_STEP + col * col_step +
                                  row * row_step) % PIXEL_RANGE);
    endfunction

    // Low byte on top, then four zero bits and the high nibble
    function automatic img_pkg::word_t stored_word(input img_pkg::pixel_t p);
        return {p[7:0], 4'h0, p[11:8]};
    endfunction

    function automatic img_pkg::word_t swap_bytes(input img_pkg::word_t w);
        return {w[7:0], w[15:8]};
    endfunction

    function automatic logic thumb_keeps(input int unsigned addr);
        return ((addr % `IMG_WIDTH) % `THUMB_GRID < THUMB_KEEP) &&
               ((addr / `IMG_WIDTH) % `THUMB_GRID < THUMB_KEEP);
    endfunction

    task automatic build_expected(input img_pkg::block_t block, input logic thumb,
                                  input stream_pkg::header_t header);
        int unsigned sum1;
        int unsigned sum2;
        int unsigned i;
        logic [31:0] fletcher;
        logic [31:0] reversed;
        expect_q.delete();
        for (i = 0; i < `HEADER_WORDS; i++) begin
            expect_q.push_back(header[16 * (`HEADER_WORDS - 1 - i) +: 16]);
        end
        for (i = 0; i < `IMG_PIXELS; i++) begin
            if (!thumb || thumb_keeps(i)) begin
                expect_q.push_back(model_mem[block][i]);
            end
        end
        // Checksum runs over header and pixels only
        sum1 = 0;
        sum2 = 0;
        for (i = 0; i < expect_q.size(); i++) begin
            sum1 = (sum1 + swap_bytes(expect_q[i])) % FLETCHER_MOD;
            sum2 = (sum2 + sum1) % FLETCHER_MOD;
        end
        fletcher = {sum2[15:0], sum1[15:0]};
        reversed = {fletcher[7:0], fletcher[15:8], fletcher[23:16], fletcher[31:24]};
        expect_q.push_back(reversed[31:16]);
        expect_q.push_back(reversed[15:0]);
        for (i = 0; i < `PAD_WORDS; i++) begin
            expect_q.push_back('0);
        end
    endtask

    // ======================================================================
    // Checking and failure
    // ======================================================================
    task automatic stop_with_failure();
        $display("** FAIL **");
        $fatal(1, "Simulation stopped on the first error");
    endtask

    task automatic check_value(input string name, input logic [63:0] actual,
                               input logic [63:0] expected);
        if (actual !== expected) begin
            $display("[FAIL] %s: got 0x%0h, expected 0x%0h", name, actual, expected);
            stop_with_failure();
        end
    endtask

    task automatic check_cycles(input int unsigned cycles, input string what);
        if (cycles > TIMEOUT_CYCLES) begin
            $display("Timed out waiting for %s", what);
            stop_with_failure();
        end
    endtask

    // Bound assertions count their failures
    always @(posedge clk) begin
        if (dut_i.u_checker.failed_count != 0) begin
            $display("A protocol assertion in the bound checker failed");
            stop_with_failure();
        end
    end

    // ======================================================================
    // Stimulus
    // ======================================================================
    task automatic send_command(input stream_pkg::cmd_t c);
        int unsigned cycles;
        cycles = 0;
        cmd <= c;
        cmd_valid <= 1'b1;
        do begin
            @(posedge clk);
            cycles++;
            check_cycles(cycles, "command acceptance");
        end while (!cmd_ready);
        cmd_valid <= 1'b0;
    endtask

    task automatic drive_frame(input int unsigned frame, input int unsigned base,
                               input int unsigned col_step, input int unsigned row_step);
        int unsigned row;
        int unsigned col;
        img_fv <= 1'b1;
        repeat (3) @(posedge clk);
        for (row = 0; row < `IMG_HEIGHT; row++) begin
            for (col = 0; col < `IMG_WIDTH; col++) begin
                img_lv <= 1'b1;
                img_d <= pattern_pixel(frame, base, col_step, row_step, col, row);
                @(posedge clk);
            end
            img_lv <= 1'b0;
            img_d <= '0;
            repeat (2) @(posedge clk);
        end
        img_fv <= 1'b0;
        @(posedge clk);
    endtask

    task automatic wait_capture_done();
        int unsigned cycles;
        cycles = 0;
        do begin
            @(posedge clk);
            cycles++;
            check_cycles(cycles, "capture_done");
        end while (!capture_done);
    endtask

    task automatic wait_idle();
        int unsigned cycles;
        cycles = 0;
        do begin
            @(posedge clk);
            cycles++;
            check_cycles(cycles, "the controller to become ready");
        end while (!cmd_ready);
    endtask

    task automatic collect_readout(input logic back_pressure);
        int unsigned idx;
        int unsigned idle;
        int unsigned cycles;
        logic seen;
        idx = 0;
        idle = 0;
        cycles = 0;
        seen = 1'b0;
        while (idx < expect_q.size()) begin
            @(posedge clk);
            cycles++;
            // Header shows up two cycles after the handshake
            if (out_valid && !seen) begin
                check_value("first_word_latency", cycles, 2);
                seen = 1'b1;
            end
            if (out_valid && out_ready) begin
                check_value("out_data", out_data, expect_q[idx]);
                check_value("out_last", out_last, idx == expect_q.size() - 1);
                idx++;
                idle = 0;
            end else begin
                idle++;
                check_cycles(idle, "the next readout word");
            end
            out_ready <= back_pressure ? 1'($urandom % 2) : 1'b1;
        end
        out_ready <= 1'b1;
    endtask

    task automatic read_block(input img_pkg::block_t block, input logic thumb,
                              input stream_pkg::header_t header, input logic back_pressure);
        stream_pkg::cmd_t c;
        build_expected(block, thumb, header);
        c = '0;
        c.op = stream_pkg::op_readout;
        c.block = block;
        c.thumb = thumb;
        c.header = header;
        send_command(c);
        collect_readout(back_pressure);
        wait_idle();
    endtask

    task automatic run_case(input img_pkg::block_t block, input img_pkg::skip_t skip,
            input logic thumb, input stream_pkg::header_t header, input logic back_pressure,
            input int unsigned base, input int unsigned col_step, input int unsigned row_step,
            input int unsigned highlights, input int unsigned shadows);
        stream_pkg::cmd_t c;
        int unsigned frame;
        int unsigned i;
        c = '0;
        c.op = stream_pkg::op_capture;
        c.block = block;
        c.skip = skip;
        send_command(c);
        // Frames before index skip must be dropped
        for (frame = 0; frame <= skip; frame++) begin
            drive_frame(frame, base, col_step, row_step);
            if (frame < skip) begin
                repeat (3) @(posedge clk);
            end
        end
        wait_capture_done();
        check_value("status.pixel_count", status.pixel_count, `IMG_PIXELS);
        check_value("status.highlight_count", status.highlight_count, highlights);
        check_value("status.shadow_count", status.shadow_count, shadows);

        for (i = 0; i < `IMG_PIXELS; i++) begin
            model_mem[block][i] = stored_word(pattern_pixel(skip, base, col_step, row_step,
                                                            i % `IMG_WIDTH, i / `IMG_WIDTH));
        end
        model_full[block] = 1'b1;
        read_block(block, thumb, header, back_pressure);

        // Other block must still hold its own frame
        if (model_full[~block]) begin
            read_block(~block, 1'b0, ~header, back_pressure);
        end
    endtask

    // ======================================================================
    // Main sequence
    // ======================================================================
    initial begin
        int fd;
        int fields;
        string line;
        int unsigned blk;
        int unsigned skp;
        int unsigned thm;
        int unsigned bp;
        int unsigned base;
        int unsigned cstep;
        int unsigned rstep;
        int unsigned hl;
        int unsigned sh;
        logic [63:0] hdr;
        void'($urandom(SEED));
        rst_n = 1'b0;
        cmd_valid = 1'b0;
        cmd = '0;
        img_fv = 1'b0;
        img_lv = 1'b0;
        img_d = '0;
        out_ready = 1'b1;
        model_full[0] = 1'b0;
        model_full[1] = 1'b0;
        cases_run = 0;

        repeat (8) @(posedge clk);
        rst_n <= 1'b1;
        @(posedge clk);
        check_value("cmd_ready", cmd_ready, 1'b1);
        check_value("out_valid", out_valid, 1'b0);
        check_value("out_last", out_last, 1'b0);
        check_value("capture_done", capture_done, 1'b0);

        fd = $fopen("bench/img_stim.txt", "r");
        if (fd == 0) begin
            $display("Could not open the stimulus file bench/img_stim.txt");
            stop_with_failure();
        end else begin
            while (!$feof(fd)) begin
                if ($fgets(line, fd) != 0) begin
                    fields = $sscanf(line, "%h %h %h %h %h %h %h %h %d %d",
                                     blk, skp, thm, hdr, bp, base, cstep, rstep, hl, sh);
                    // Comment lines fail the scan and are skipped
                    if (fields == 10) begin
                        run_case(blk[0], skp[1:0], thm[0], hdr, bp[0], base, cstep, rstep,
                                 hl, sh);
                        cases_run++;
                    end
                end
            end
            $fclose(fd);
            if (cases_run != 0 && dut_i.u_checker.failed_count == 0) begin
                $display("** PASS **");
                $finish;
            end else begin
                $display("No test case ran, or a bound assertion failed");
                stop_with_failure();
            end
        end
    end

endmodule

/* bench/img_stim.txt */
# block skip thumb header back_pressure base col_step row_step highlights shadows
# All fields are hex except the two expected counts, which are decimal
0 0 0 a5a5000100020003 0 000 001 010 0 4
1 1 0 1234567890abcdef 0 f7f 001 002 14 2
0 0 1 fedcba9876543210 0 123 003 028 0 0
1 2 0 0f0f0f0fffff0000 1 800 005 04d 0 0
0 3 1 cafe0001beef0002 1 edd fff 008 3 4
1 0 0 ffffffffffffffff 1 ff0 001 100 4 0
0 1 1 0000000000000000 0 fbf fff fe0 0 3
1 0 0 8000000000000001 0 005 000 000 0 16

/* project.f */
+incdir+source
source/img_pkg.sv
source/stream_pkg.sv
source/fletcher_checksum.sv
source/frame_buffer.sv
source/pixel_capture.sv
source/readout_engine.sv
source/img_controller.sv
bench/img_controller_checker.sv
bench/img_controller_tb.sv

/* Bender.yml */
package:
  name: img_controller

sources:
  - include_dirs:
      - source
    files:
      - source/img_pkg.sv
      - source/stream_pkg.sv
      - source/fletcher_checksum.sv
      - source/frame_buffer.sv
      - source/pixel_capture.sv
      - source/readout_engine.sv
      - source/img_controller.sv
  - target: test
    include_dirs:
      - source
    files:
      - bench/img_controller_checker.sv
      - bench/img_controller_tb.sv
